/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_slt = 4'd4
    } alu_op_t;

    // write-back value select
    typedef enum logic [1:0] {
        res_alu = 2'd0,
        res_mem = 2'd1,
        res_pc4 = 2'd2
    } result_src_t;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_wb   = 2'd1,
        fwd_mem  = 2'd2
    } fwd_sel_t;

    // rv32i major opcodes kept by this core
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_i      = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

endpackage

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1_d,
    input  rv_pkg::reg_idx_t rs2_d,
    input  rv_pkg::reg_idx_t rs1_e,
    input  rv_pkg::reg_idx_t rs2_e,
    input  rv_pkg::reg_idx_t rd_e,
    input  rv_pkg::reg_idx_t rd_m,
    input  rv_pkg::reg_idx_t rd_w,
    input  logic             load_e,
    input  logic             pc_src_e,
    input  logic             reg_write_m,
    input  logic             reg_write_w,
    input  logic             mem_access_m,
    input  logic             cache_data_valid,
    output logic             stall_f,
    output logic             stall_d,
    output logic             stall_e,
    output logic             stall_m,
    output logic             stall_w,
    output logic             flush_d,
    output logic             flush_e,
    output rv_pkg::fwd_sel_t fwd_a,
    output rv_pkg::fwd_sel_t fwd_b
);
    import rv_pkg::*;

    logic mem_wait;
    logic load_use;

    // data memory has not answered yet
    assign mem_wait = mem_access_m & ~cache_data_valid;
    assign load_use = load_e && (rd_e != '0) && ((rd_e == rs1_d) || (rd_e == rs2_d));

    assign stall_f = load_use | mem_wait;
    assign stall_d = load_use | mem_wait;
    assign stall_e = mem_wait;
    assign stall_m = mem_wait;
    assign stall_w = mem_wait;

    // a held branch redirects only once the wait is over
    assign flush_d = pc_src_e & ~mem_wait;
    assign flush_e = (pc_src_e | load_use) & ~mem_wait;

    // newest producer wins
    assign fwd_a = (reg_write_m && rd_m != '0 && rd_m == rs1_e) ? fwd_mem :
                   (reg_write_w && rd_w != '0 && rd_w == rs1_e) ? fwd_wb : fwd_none;
    assign fwd_b = (reg_write_m && rd_m != '0 && rd_m == rs2_e) ? fwd_mem :
                   (reg_write_w && rd_w != '0 && rd_w == rs2_e) ? fwd_wb : fwd_none;

    // execute keeps its instruction through a memory wait
    a_no_flush_in_wait: assert property (@(posedge clk) disable iff (rst)
        mem_wait |=> $stable(rd_e) && $stable(load_e));

    // the load-use bubble clears the hazard after one cycle
    a_load_use_once: assert property (@(posedge clk) disable iff (rst)
        load_use && !mem_wait |=> !load_use);

endmodule

`default_nettype wire

/* src/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic                clk,
    input  logic                rst,
    input  rv_pkg::word_t       instr_d,
    output rv_pkg::reg_idx_t    rs1_d,
    output rv_pkg::reg_idx_t    rs2_d,
    output rv_pkg::reg_idx_t    rd_d,
    output rv_pkg::word_t       rd1,
    output rv_pkg::word_t       rd2,
    output rv_pkg::word_t       imm,
    output rv_pkg::alu_op_t     alu_op,
    output logic                alu_src_imm,
    output rv_pkg::result_src_t result_src,
    output logic                reg_write,
    output logic                mem_write,
    output logic                branch,
    output logic                branch_ne,
    output logic                jump,
    input  logic                reg_write_w,
    input  rv_pkg::reg_idx_t    rd_w,
    input  rv_pkg::word_t       result_w
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      regs [32];

    assign opcode = opcode_t'(instr_d[6:0]);
    assign funct3 = instr_d[14:12];
    assign rs1_d  = instr_d[19:15];
    assign rs2_d  = instr_d[24:20];
    assign rd_d   = instr_d[11:7];

    always_comb begin
        alu_op      = alu_add;
        alu_src_imm = 1'b0;
        result_src  = res_alu;
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        jump        = 1'b0;
        imm         = '0;
        case (opcode)
            op_r, op_i: begin
                reg_write   = 1'b1;
                alu_src_imm = (opcode == op_i);
                imm         = {{20{instr_d[31]}}, instr_d[31:20]};
                case (funct3)
                    3'b111:  alu_op = alu_and;
                    3'b110:  alu_op = alu_or;
                    3'b010:  alu_op = alu_slt;
                    // funct7 bit 5 only means sub for register ops
                    default: alu_op = (opcode == op_r && instr_d[30]) ? alu_sub : alu_add;
                endcase
            end
            op_load: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                result_src  = res_mem;
                imm         = {{20{instr_d[31]}}, instr_d[31:20]};
            end
            op_store: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
            end
            op_branch: begin
                branch    = 1'b1;
                branch_ne = funct3[0];
                alu_op    = alu_sub;
                imm       = {{20{instr_d[31]}}, instr_d[7], instr_d[30:25],
                             instr_d[11:8], 1'b0};
            end
            op_jal: begin
                jump       = 1'b1;
                reg_write  = 1'b1;
                result_src = res_pc4;
                imm        = {{12{instr_d[31]}}, instr_d[19:12], instr_d[20],
                              instr_d[30:21], 1'b0};
            end
            // anything else is a bubble
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write_w && rd_w != '0) begin
            regs[rd_w] <= result_w;
        end
    end

    // write-back value wins over the array in the same cycle
    assign rd1 = (rs1_d == '0) ? '0 :
                 (reg_write_w && rd_w == rs1_d) ? result_w : regs[rs1_d];
    assign rd2 = (rs2_d == '0) ? '0 :
                 (reg_write_w && rd_w == rs2_d) ? result_w : regs[rs2_d];

endmodule

`default_nettype wire

/* src/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  rv_pkg::word_t    rd1_e,
    input  rv_pkg::word_t    rd2_e,
    input  rv_pkg::word_t    imm_e,
    input  rv_pkg::word_t    pc_e,
    input  rv_pkg::alu_op_t  alu_op_e,
    input  logic             alu_src_imm_e,
    input  logic             branch_e,
    input  logic             branch_ne_e,
    input  logic             jump_e,
    input  rv_pkg::fwd_sel_t fwd_a,
    input  rv_pkg::fwd_sel_t fwd_b,
    input  rv_pkg::word_t    alu_result_m,
    input  rv_pkg::word_t    result_w,
    output rv_pkg::word_t    alu_result_e,
    output rv_pkg::word_t    write_data_e,
    output rv_pkg::word_t    pc_target_e,
    output logic             pc_src_e
);
    import rv_pkg::*;

    word_t src_a;
    word_t src_b;
    logic  equal;

    always_comb begin
        case (fwd_a)
            fwd_mem: src_a = alu_result_m;
            fwd_wb:  src_a = result_w;
            default: src_a = rd1_e;
        endcase
        case (fwd_b)
            fwd_mem: write_data_e = alu_result_m;
            fwd_wb:  write_data_e = result_w;
            default: write_data_e = rd2_e;
        endcase
    end

    assign src_b = alu_src_imm_e ? imm_e : write_data_e;

    always_comb begin
        case (alu_op_e)
            alu_sub: alu_result_e = src_a - src_b;
            alu_and: alu_result_e = src_a & src_b;
            alu_or:  alu_result_e = src_a | src_b;
            alu_slt: alu_result_e = {31'b0, $signed(src_a) < $signed(src_b)};
            default: alu_result_e = src_a + src_b;
        endcase
    end

    // beq and bne compare the two register operands
    assign equal       = (src_a == write_data_e);
    assign pc_src_e    = (branch_e & (equal ^ branch_ne_e)) | jump_e;
    assign pc_target_e = pc_e + imm_e;

    // a redirect lands on a word boundary
    always_comb begin
        a_target_aligned: assert final (pc_src_e !== 1'b1 || pc_target_e[1:0] == 2'b00)
            else $error("redirect to a target that is not word aligned");
    end

endmodule

`default_nettype wire

/* src/riscv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline #(
    parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst,
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t pc,
    output logic          en_instr_mem,
    input  rv_pkg::word_t read_data,
    input  logic          cache_data_valid,
    output logic          data_we,
    output rv_pkg::word_t data_addr,
    output rv_pkg::word_t din
);
    import rv_pkg::*;

    word_t       pc_plus4_f, instr_d, pc_d, pc_plus4_d;
    reg_idx_t    rs1_d, rs2_d, rd_d;
    word_t       rd1, rd2, imm;
    alu_op_t     alu_op;
    result_src_t result_src;
    logic        alu_src_imm, reg_write, mem_write, branch, branch_ne, jump;

    word_t       rd1_e, rd2_e, imm_e, pc_e, pc_plus4_e;
    reg_idx_t    rs1_e, rs2_e, rd_e;
    alu_op_t     alu_op_e;
    result_src_t result_src_e;
    logic        alu_src_imm_e, reg_write_e, mem_write_e, branch_e, branch_ne_e, jump_e;
    word_t       alu_result_e, write_data_e, pc_target_e;
    logic        pc_src_e, load_e;

    word_t       alu_result_m, write_data_m, pc_plus4_m, fwd_value_m;
    reg_idx_t    rd_m;
    result_src_t result_src_m;
    logic        reg_write_m, mem_write_m, mem_access_m;

    word_t       alu_result_w, read_data_w, pc_plus4_w, result_w;
    reg_idx_t    rd_w;
    result_src_t result_src_w;
    logic        reg_write_w;

    logic        stall_f, stall_d, stall_e, stall_m, stall_w, flush_d, flush_e;
    fwd_sel_t    fwd_a, fwd_b;

    // fetch
    assign pc_plus4_f   = pc + 32'd4;
    assign en_instr_mem = ~stall_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (!stall_f) begin
            pc <= pc_src_e ? pc_target_e : pc_plus4_f;
        end
    end

    // fetch to decode, all-zero instr decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            instr_d <= '0;
        end else if (!stall_d) begin
            instr_d <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            pc_d       <= pc;
            pc_plus4_d <= pc_plus4_f;
        end
    end

    instr_decode instr_decode_inst (.*);

    // decode to execute
    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            reg_write_e   <= 1'b0;
            mem_write_e   <= 1'b0;
            result_src_e  <= res_alu;
            branch_e      <= 1'b0;
            branch_ne_e   <= 1'b0;
            jump_e        <= 1'b0;
            alu_op_e      <= alu_add;
            alu_src_imm_e <= 1'b0;
            rd_e          <= '0;
        end else if (!stall_e) begin
            reg_write_e   <= reg_write;
            mem_write_e   <= mem_write;
            result_src_e  <= result_src;
            branch_e      <= branch;
            branch_ne_e   <= branch_ne;
            jump_e        <= jump;
            alu_op_e      <= alu_op;
            alu_src_imm_e <= alu_src_imm;
            rd_e          <= rd_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_e) begin
            rd1_e      <= rd1;
            rd2_e      <= rd2;
            imm_e      <= imm;
            pc_e       <= pc_d;
            pc_plus4_e <= pc_plus4_d;
            rs1_e      <= rs1_d;
            rs2_e      <= rs2_d;
        end
    end

    assign load_e = (result_src_e == res_mem);

    // a jal in memory forwards its link address
    assign fwd_value_m = (result_src_m == res_pc4) ? pc_plus4_m : alu_result_m;

    exec_stage exec_stage_inst (.*, .alu_result_m(fwd_value_m));

    // execute to memory
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
            result_src_m <= res_alu;
        end else if (!stall_m) begin
            reg_write_m  <= reg_write_e;
            mem_write_m  <= mem_write_e;
            result_src_m <= result_src_e;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_m) begin
            alu_result_m <= alu_result_e;
            write_data_m <= write_data_e;
            pc_plus4_m   <= pc_plus4_e;
            rd_m         <= rd_e;
        end
    end

    // held steady by stall_m while the memory waits
    assign data_we      = mem_write_m;
    assign data_addr    = alu_result_m;
    assign din          = write_data_m;
    assign mem_access_m = (result_src_m == res_mem) | mem_write_m;

    // memory to write-back
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_w  <= 1'b0;
            result_src_w <= res_alu;
        end else if (!stall_w) begin
            reg_write_w  <= reg_write_m;
            result_src_w <= result_src_m;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_w) begin
            alu_result_w <= alu_result_m;
            read_data_w  <= read_data;
            pc_plus4_w   <= pc_plus4_m;
            rd_w         <= rd_m;
        end
    end

    always_comb begin
        case (result_src_w)
            res_mem: result_w = read_data_w;
            res_pc4: result_w = pc_plus4_w;
            default: result_w = alu_result_w;
        endcase
    end

    hazard_unit hazard_unit_inst (.*);

endmodule

`default_nettype wire

/* dv/store_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module store_checker (
    input  logic          clk,
    input  logic          rst,
    input  logic          en_instr_mem,
    input  logic          data_we,
    input  logic          cache_data_valid,
    input  rv_pkg::word_t data_addr,
    input  rv_pkg::word_t din,
    output int            seen,
    output int            pass_count,
    output int            fail_count
);

    // a store commits on the edge where the memory accepts it
    always @(posedge clk) begin
        if (rst) begin
            seen       <= 0;
            pass_count <= 0;
            fail_count <= 0;
        end else if (data_we && cache_data_valid) begin
            seen <= seen + 1;
            if (seen >= tb_riscv_pipeline.exp_count) begin
                $display("unexpected store of %h to address %h after the last expected store",
                         din, data_addr);
                fail_count <= fail_count + 1;
            end else if (data_addr === tb_riscv_pipeline.exp_addr[seen] &&
                         din === tb_riscv_pipeline.exp_data[seen]) begin
                $display("ok %0s: %h at address %h", tb_riscv_pipeline.exp_name[seen],
                         din, data_addr);
                pass_count <= pass_count + 1;
            end else begin
                $display("FAILED %0s: expected %h at address %h, actual %h at address %h",
                         tb_riscv_pipeline.exp_name[seen], tb_riscv_pipeline.exp_data[seen],
                         tb_riscv_pipeline.exp_addr[seen], din, data_addr);
                fail_count <= fail_count + 1;
            end
        end else if (data_we && en_instr_mem) begin
            // a waiting store holds fetch as well
            $display("fetch kept running while a store waited for the data memory");
            fail_count <= fail_count + 1;
        end
    end

    task automatic report_missing(output int missing);
        missing = 0;
        for (int i = seen; i < tb_riscv_pipeline.exp_count; i++) begin
            $display("store for test %0s never happened", tb_riscv_pipeline.exp_name[i]);
            missing++;
        end
    endtask

endmodule

`default_nettype wire

/* dv/tb_riscv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_pipeline;
    import rv_pkg::*;

    logic  clk;
    logic  rst;
    word_t instr;
    word_t pc;
    logic  en_instr_mem;
    word_t read_data;
    logic  cache_data_valid;
    logic  data_we;
    word_t data_addr;
    word_t din;

    word_t           imem [64];
    word_t           dmem [256];
    word_t           exp_addr [64];
    word_t           exp_data [64];
    logic [8*24-1:0] exp_name [64];

    int   exp_count;
    int   instr_count;
    int   vector_lines;
    int   cycle_limit;
    int   cycles;
    int   missing;
    int   wait_left;
    int   seed = 34498;
    int   seen;
    int   pass_count;
    int   fail_count;
    logic file_ok;
    logic timed_out;
    logic finished;

    riscv_pipeline riscv_pipeline_inst (
        .clk              (clk),
        .rst              (rst),
        .instr            (instr),
        .pc               (pc),
        .en_instr_mem     (en_instr_mem),
        .read_data        (read_data),
        .cache_data_valid (cache_data_valid),
        .data_we          (data_we),
        .data_addr        (data_addr),
        .din              (din)
    );

    store_checker store_checker_inst (
        .clk              (clk),
        .rst              (rst),
        .en_instr_mem     (en_instr_mem),
        .data_we          (data_we),
        .cache_data_valid (cache_data_valid),
        .data_addr        (data_addr),
        .din              (din),
        .seen             (seen),
        .pass_count       (pass_count),
        .fail_count       (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // I lines fill the instruction memory, S lines the expected stores
    task automatic load_vectors;
        int              fd;
        int              code;
        logic [8*16-1:0] tag;
        logic [8*128-1:0] rest;
        word_t           a;
        word_t           d;
        logic [8*24-1:0] name;
        file_ok = 1'b1;
        fd = $fopen("dv/program_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/program_vectors.txt");
            file_ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                tag = '0;
                code = $fscanf(fd, "%s", tag);
                if (code == 1 && tag == "I" && instr_count < 64) begin
                    code = $fscanf(fd, "%h", a);
                    imem[instr_count] = a;
                    instr_count++;
                    vector_lines++;
                end else if (code == 1 && tag == "S" && exp_count < 64) begin
                    name = '0;
                    code = $fscanf(fd, "%h %h %s", a, d, name);
                    exp_addr[exp_count] = a;
                    exp_data[exp_count] = d;
                    exp_name[exp_count] = name;
                    exp_count++;
                    vector_lines++;
                end else if (code == 1 && tag != "#") begin
                    $display("bad line in vector file starting with %0s", tag);
                    file_ok = 1'b0;
                end
                // trailing assembly text or comment
                if (code == 1) begin
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // fetch and data memory respond on the falling edge
    always @(negedge clk) begin
        instr     <= imem[pc[7:2]];
        read_data <= dmem[data_addr[9:2]];
        if (rst) begin
            cache_data_valid <= 1'b1;
        end else if (cache_data_valid) begin
            wait_left = $random(seed) & 3;
            cache_data_valid <= (wait_left == 0);
            if (wait_left != 0) begin
                wait_left = wait_left - 1;
            end
        end else if (wait_left == 0) begin
            cache_data_valid <= 1'b1;
        end else begin
            wait_left = wait_left - 1;
        end
    end

    always @(posedge clk) begin
        if (!rst && data_we && cache_data_valid) begin
            dmem[data_addr[9:2]] <= din;
        end
    end

    initial begin
        rst              = 1'b1;
        instr            = '0;
        read_data        = '0;
        cache_data_valid = 1'b1;
        wait_left        = 0;
        exp_count        = 0;
        instr_count      = 0;
        vector_lines     = 0;
        cycles           = 0;
        missing          = 0;
        timed_out        = 1'b0;
        finished         = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = '0;
        end
        load_vectors();
        cycle_limit = 20 * vector_lines + 100;

        repeat (3) @(negedge clk);
        rst = 1'b0;

        if (file_ok) begin
            while (!finished) begin
                @(negedge clk);
                cycles++;
                if (seen >= exp_count) begin
                    finished = 1'b1;
                end else if (cycles >= cycle_limit) begin
                    timed_out = 1'b1;
                    finished  = 1'b1;
                end
            end
            if (timed_out) begin
                $display("run timed out after %0d cycles with %0d of %0d stores seen",
                         cycles, seen, exp_count);
            end else begin
                // a few more cycles so a stray store still shows up
                repeat (10) @(negedge clk);
            end
        end

        store_checker_inst.report_missing(missing);
        $display("stores passed: %0d, failed: %0d", pass_count, fail_count + missing);
        if (!file_ok || timed_out || fail_count != 0 || missing != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/program_vectors.txt */
# I <instruction hex> <assembly>, one per word from address 0
# S <store address hex> <store data hex> <test name>, in program order
I 10000513 addi x10, x0, 256
I 00C00093 addi x1, x0, 12
I FFB00113 addi x2, x0, -5
I 002081B3 add  x3, x1, x2
I 00352023 sw   x3, 0(x10)
I 40208233 sub  x4, x1, x2
I 00452223 sw   x4, 4(x10)
I 0020F2B3 and  x5, x1, x2
I 00552423 sw   x5, 8(x10)
I 0020E333 or   x6, x1, x2
I 00652623 sw   x6, 12(x10)
I 001123B3 slt  x7, x2, x1
I 00752823 sw   x7, 16(x10)
I 0060F413 andi x8, x1, 6
I 00852A23 sw   x8, 20(x10)
I 0300E493 ori  x9, x1, 0x30
I 00952C23 sw   x9, 24(x10)
I 00100593 addi x11, x0, 1
I 00B585B3 add  x11, x11, x11
I 001585B3 add  x11, x11, x1
I 00B58633 add  x12, x11, x11
I 00B60633 add  x12, x12, x11
I 00C52E23 sw   x12, 28(x10)
I 01C52683 lw   x13, 28(x10)
I 06468713 addi x14, x13, 100
I 02E52023 sw   x14, 32(x10)
I 00318663 beq  x3, x3, +12
I 02252223 sw   x2, 36(x10) poison
I 02252423 sw   x2, 40(x10) poison
I 00419663 bne  x3, x4, +12
I 02252223 sw   x2, 36(x10) poison
I 02252423 sw   x2, 40(x10) poison
I 00418463 beq  x3, x4, +8 not taken
I 02152223 sw   x1, 36(x10)
I 00319463 bne  x3, x3, +8 not taken
I 02452423 sw   x4, 40(x10)
I 00C007EF jal  x15, +12
I 02252623 sw   x2, 44(x10) poison
I 02252823 sw   x2, 48(x10) poison
I 02F52623 sw   x15, 44(x10)
I 00478813 addi x16, x15, 4
I 03052823 sw   x16, 48(x10)
I 0000006F jal  x0, 0
S 00000100 00000007 alu_add
S 00000104 00000011 alu_sub
S 00000108 00000008 alu_and
S 0000010C FFFFFFFF alu_or
S 00000110 00000001 alu_slt_negative
S 00000114 00000004 alu_andi
S 00000118 0000003C alu_ori
S 0000011C 0000002A forward_chain
S 00000120 0000008E load_use
S 00000124 0000000C beq_taken_then_fall
S 00000128 00000011 bne_taken_then_fall
S 0000012C 00000094 jal_link
S 00000130 00000098 jal_target

/* files.f */
src/rv_pkg.sv
src/hazard_unit.sv
src/instr_decode.sv
src/exec_stage.sv
src/riscv_pipeline.sv
dv/store_checker.sv
dv/tb_riscv_pipeline.sv
